//--- ow_defines.svh
`ifndef OW_DEFINES_SVH
`define OW_DEFINES_SVH

// Strobe cycles per microsecond tick.
`define OW_TICK_DIV 4

// Reset slot timing in ticks.
`define OW_RESET_LOW        480
`define OW_PRESENCE_SAMPLE  70   // Counted from the release of the reset pulse.
`define OW_RESET_TOTAL      960

// Write and read slot timing in ticks.
`define OW_SLOT        65
`define OW_WRITE1_LOW  6
`define OW_WRITE0_LOW  60
`define OW_READ_LOW    6
`define OW_READ_SAMPLE 15

// Command bytes.
`define OW_CMD_SKIP_ROM     8'hCC
`define OW_CMD_CONVERT      8'h44
`define OW_CMD_READ_SCRATCH 8'hBE

// Read slots polled before the conversion is given up.
`define OW_POLL_LIMIT 64

`endif

//--- ow_bus_pkg.sv
`default_nettype none

package ow_bus_pkg;

    // One timed action on the line.
    typedef enum logic [1:0] {
        SLOT_RESET  = 2'd0,
        SLOT_WRITE0 = 2'd1,
        SLOT_WRITE1 = 2'd2,
        SLOT_READ   = 2'd3
    } slot_op_t;

    typedef enum logic [2:0] {
        PH_IDLE     = 3'd0,
        PH_RESET    = 3'd1,
        PH_SKIP_ROM = 3'd2,
        PH_CONVERT  = 3'd3,
        PH_POLL     = 3'd4, // Waits for the conversion to finish.
        PH_READ_CMD = 3'd5,
        PH_READ     = 3'd6,
        PH_FINISH   = 3'd7  // Closing reset.
    } phase_t;

endpackage

`default_nettype wire

//--- temp_pkg.sv
`default_nettype none

package temp_pkg;

    // Scratchpad bytes 0 and 1 in sixteenths of a degree.
    typedef struct packed {
        logic [4:0] sign;  // Copies of the sign bit.
        logic [6:0] whole;
        logic [3:0] frac;
    } temp_fields_t;

    // Same word as shifted in from the bus and as decoded.
    typedef union packed {
        logic [15:0]  raw;
        temp_fields_t fields;
    } temp_word_u;

endpackage

`default_nettype wire

//--- ow_line_input.sv
`timescale 1ns/1ps
`default_nettype none
`include "ow_defines.svh"

module ow_line_input (
    input  logic strobe,
    input  logic rst,
    input  logic line_in,
    output logic us_tick,
    output logic line_sync
);

    localparam int DIV_W = (`OW_TICK_DIV > 1) ? $clog2(`OW_TICK_DIV) : 1;
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`OW_TICK_DIV - 1);

    logic [DIV_W-1:0] div_cnt;
    logic             line_meta;

    always_ff @(posedge strobe or posedge rst) begin
        if (rst) begin
            div_cnt   <= '0;
            us_tick   <= 1'b0;
            line_meta <= 1'b1; // Released bus reads high.
            line_sync <= 1'b1;
        end else begin
            us_tick   <= (div_cnt == DIV_LAST);
            div_cnt   <= (div_cnt == DIV_LAST) ? '0 : div_cnt + 1'b1;
            line_meta <= line_in;
            line_sync <= line_meta;
        end
    end

    a_tick_single: assert property (
        @(posedge strobe) disable iff (rst) us_tick |=> !us_tick
    );

endmodule

`default_nettype wire

//--- ow_slot_engine.sv
`timescale 1ns/1ps
`default_nettype none
`include "ow_defines.svh"

module ow_slot_engine import ow_bus_pkg::*; (
    input  logic     strobe,
    input  logic     rst,
    input  logic     us_tick,
    input  logic     line_sync,
    input  logic     slot_start,
    input  slot_op_t slot_op,
    output logic     slot_busy,
    output logic     slot_done,
    output logic     slot_bit,
    output logic     line_drive_low
);

    localparam int CNT_W = $clog2(`OW_RESET_TOTAL + 1);

    slot_op_t         op_q;
    logic [CNT_W-1:0] tick_cnt;    // Ticks since the slot began.
    logic [CNT_W-1:0] low_last;
    logic [CNT_W-1:0] sample_last;
    logic [CNT_W-1:0] end_last;
    logic             sample_en;
    logic             sample_q;

    // Timing of the latched operation as the last tick of each interval.
    always_comb begin
        low_last    = CNT_W'(`OW_READ_LOW - 1);
        sample_last = CNT_W'(`OW_READ_SAMPLE - 1);
        end_last    = CNT_W'(`OW_SLOT - 1);
        sample_en   = 1'b0;
        case (op_q)
            SLOT_RESET: begin
                low_last    = CNT_W'(`OW_RESET_LOW - 1);
                sample_last = CNT_W'(`OW_RESET_LOW + `OW_PRESENCE_SAMPLE - 1);
                end_last    = CNT_W'(`OW_RESET_TOTAL - 1);
                sample_en   = 1'b1;
            end
            SLOT_WRITE0: begin
                low_last = CNT_W'(`OW_WRITE0_LOW - 1);
            end
            SLOT_WRITE1: begin
                low_last = CNT_W'(`OW_WRITE1_LOW - 1);
            end
            default: begin
                sample_en = 1'b1; // Read slot.
            end
        endcase
    end

    always_ff @(posedge strobe or posedge rst) begin
        if (rst) begin
            op_q           <= SLOT_RESET;
            tick_cnt       <= '0;
            slot_busy      <= 1'b0;
            slot_done      <= 1'b0;
            slot_bit       <= 1'b0;
            sample_q       <= 1'b0;
            line_drive_low <= 1'b0;
        end else begin
            slot_done <= 1'b0;
            if (slot_start && !slot_busy) begin
                op_q           <= slot_op;
                tick_cnt       <= '0;
                sample_q       <= 1'b0;
                slot_busy      <= 1'b1;
                line_drive_low <= 1'b1; // Every slot opens with the line low.
            end else if (slot_busy && us_tick) begin
                tick_cnt <= tick_cnt + 1'b1;
                if (tick_cnt == low_last) begin
                    line_drive_low <= 1'b0;
                end
                // A presence pulse holds the line low, so it reads inverted.
                if (sample_en && tick_cnt == sample_last) begin
                    sample_q <= (op_q == SLOT_RESET) ? !line_sync : line_sync;
                end
                if (tick_cnt == end_last) begin
                    slot_busy <= 1'b0;
                    slot_done <= 1'b1;
                    slot_bit  <= sample_q;
                end
            end
        end
    end

    a_start_when_idle: assert property (
        @(posedge strobe) disable iff (rst) slot_start |-> !slot_busy
    );

    a_drive_in_slot: assert property (
        @(posedge strobe) disable iff (rst) !slot_busy |-> !line_drive_low
    );

endmodule

`default_nettype wire

//--- ow_sequencer.sv
`timescale 1ns/1ps
`default_nettype none
`include "ow_defines.svh"

module ow_sequencer import ow_bus_pkg::*, temp_pkg::*; (
    input  logic              strobe,
    input  logic              rst,
    input  logic              read_request,
    input  logic              slot_busy,
    input  logic              slot_done,
    input  logic              slot_bit,
    output logic              slot_start,
    output slot_op_t          slot_op,
    output logic              busy,
    output logic              temp_valid,
    output logic              no_device,
    output phase_t            phase,
    output logic [15:0]       temp_raw,
    output logic signed [7:0] temp_whole,
    output logic [3:0]        temp_frac
);

    localparam int POLL_W = $clog2(`OW_POLL_LIMIT);
    localparam logic [POLL_W-1:0] POLL_LAST = POLL_W'(`OW_POLL_LIMIT - 1);

    logic [7:0]        cmd_shift;   // Command byte that goes out LSB first.
    logic [3:0]        bit_cnt;
    logic [POLL_W-1:0] poll_cnt;
    logic              waiting;     // A slot is issued and not yet done.
    logic              second_pass; // Set once the conversion is done.
    temp_word_u        word;

    assign slot_start = (phase != PH_IDLE) && !waiting && !slot_busy;

    always_comb begin
        case (phase)
            PH_SKIP_ROM, PH_CONVERT, PH_READ_CMD:
                slot_op = cmd_shift[0] ? SLOT_WRITE1 : SLOT_WRITE0;
            PH_POLL, PH_READ:
                slot_op = SLOT_READ;
            default:
                slot_op = SLOT_RESET;
        endcase
    end

    always_ff @(posedge strobe or posedge rst) begin
        if (rst) begin
            phase       <= PH_IDLE;
            busy        <= 1'b0;
            temp_valid  <= 1'b0;
            no_device   <= 1'b0;
            waiting     <= 1'b0;
            second_pass <= 1'b0;
            bit_cnt     <= '0;
            poll_cnt    <= '0;
            temp_raw    <= '0;
            temp_whole  <= '0;
            temp_frac   <= '0;
        end else begin
            temp_valid <= 1'b0;
            no_device  <= 1'b0;
            if (slot_start) begin
                waiting <= 1'b1;
            end else if (slot_done) begin
                waiting <= 1'b0;
            end
            bit_cnt <= slot_done ? bit_cnt + 1'b1 : bit_cnt;
            case (phase)
                PH_IDLE: begin
                    if (read_request) begin
                        phase       <= PH_RESET;
                        busy        <= 1'b1;
                        second_pass <= 1'b0;
                    end
                end
                PH_RESET: begin
                    bit_cnt <= '0;
                    if (slot_done && !slot_bit) begin
                        no_device <= 1'b1;
                        busy      <= 1'b0;
                        phase     <= PH_IDLE;
                    end else if (slot_done) begin
                        phase <= PH_SKIP_ROM;
                    end
                end
                PH_SKIP_ROM: begin
                    if (slot_done && bit_cnt == 4'd7) begin
                        bit_cnt <= '0;
                        phase   <= second_pass ? PH_READ_CMD : PH_CONVERT;
                    end
                end
                PH_CONVERT: begin
                    poll_cnt <= '0;
                    if (slot_done && bit_cnt == 4'd7) begin
                        phase <= PH_POLL;
                    end
                end
                PH_POLL: begin
                    if (slot_done && slot_bit) begin
                        second_pass <= 1'b1;
                        phase       <= PH_RESET;
                    end else if (slot_done && poll_cnt == POLL_LAST) begin
                        no_device <= 1'b1;
                        busy      <= 1'b0;
                        phase     <= PH_IDLE;
                    end else if (slot_done) begin
                        poll_cnt <= poll_cnt + 1'b1;
                    end
                end
                PH_READ_CMD: begin
                    if (slot_done && bit_cnt == 4'd7) begin
                        bit_cnt <= '0;
                        phase   <= PH_READ;
                    end
                end
                PH_READ: begin
                    if (slot_done && bit_cnt == 4'd15) begin
                        phase <= PH_FINISH;
                    end
                end
                default: begin
                    if (slot_done) begin // Closing reset ends the scratchpad read.
                        temp_raw   <= word.raw;
                        temp_whole <= {word.fields.sign[0], word.fields.whole};
                        temp_frac  <= word.fields.frac;
                        temp_valid <= 1'b1;
                        busy       <= 1'b0;
                        phase      <= PH_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge strobe) begin
        if (phase == PH_RESET) begin
            cmd_shift <= `OW_CMD_SKIP_ROM;
        end else if (phase == PH_SKIP_ROM && slot_done && bit_cnt == 4'd7) begin
            cmd_shift <= second_pass ? `OW_CMD_READ_SCRATCH : `OW_CMD_CONVERT;
        end else if (slot_done) begin
            cmd_shift <= {1'b0, cmd_shift[7:1]};
        end
        if (phase == PH_READ && slot_done) begin
            word.raw <= {slot_bit, word.raw[15:1]}; // Bits arrive LSB first.
        end
    end

    a_result_exclusive: assert property (
        @(posedge strobe) disable iff (rst) !(temp_valid && no_device)
    );

endmodule

`default_nettype wire

//--- ow_temp_reader.sv
`timescale 1ns/1ps
`default_nettype none

module ow_temp_reader import ow_bus_pkg::*; (
    input  logic              strobe,
    input  logic              rst,
    input  logic              read_request,
    input  logic              line_in,
    output logic              line_drive_low,
    output logic              busy,
    output logic              temp_valid,
    output logic [15:0]       temp_raw,
    output logic signed [7:0] temp_whole,
    output logic [3:0]        temp_frac,
    output logic              no_device,
    output phase_t            phase
);

    logic     us_tick;
    logic     line_sync;
    logic     slot_start;
    logic     slot_busy;
    logic     slot_done;
    logic     slot_bit;
    slot_op_t slot_op;

    // Input side.
    ow_line_input i_line_input (
        .strobe    (strobe),
        .rst       (rst),
        .line_in   (line_in),
        .us_tick   (us_tick),
        .line_sync (line_sync)
    );

    ow_sequencer i_sequencer (
        .strobe       (strobe),
        .rst          (rst),
        .read_request (read_request),
        .slot_busy    (slot_busy),
        .slot_done    (slot_done),
        .slot_bit     (slot_bit),
        .slot_start   (slot_start),
        .slot_op      (slot_op),
        .busy         (busy),
        .temp_valid   (temp_valid),
        .no_device    (no_device),
        .phase        (phase),
        .temp_raw     (temp_raw),
        .temp_whole   (temp_whole),
        .temp_frac    (temp_frac)
    );

    // Output side that times the line.
    ow_slot_engine i_slot_engine (
        .strobe         (strobe),
        .rst            (rst),
        .us_tick        (us_tick),
        .line_sync      (line_sync),
        .slot_start     (slot_start),
        .slot_op        (slot_op),
        .slot_busy      (slot_busy),
        .slot_done      (slot_done),
        .slot_bit       (slot_bit),
        .line_drive_low (line_drive_low)
    );

endmodule

`default_nettype wire

//--- ds18b20_model.sv
`timescale 1ns/1ps
`default_nettype none
`include "ow_defines.svh"

module ds18b20_model #(
    parameter int TICK_NS = 40
) (
    input  logic        strobe,
    input  logic        master_low,   // DUT pulls the bus low.
    input  logic        present,
    input  logic [15:0] temp_word,
    input  int          busy_polls,
    output logic        line,
    output int          proto_errors
);

    localparam int SHORT_MAX = 15 * TICK_NS;  // Write 1 and read slots.
    localparam int W0_MIN    = 50 * TICK_NS;
    localparam int W0_MAX    = 60 * TICK_NS;
    localparam int RESET_MIN = 470 * TICK_NS;

    typedef enum logic [1:0] {M_ROM, M_FUNC, M_POLL, M_SCRATCH} mode_t;

    mode_t      mode = M_ROM;
    logic       model_low = 1'b0;
    logic       send_bit;
    logic       hold;
    logic       conv_done = 1'b0;
    logic       read_ok = 1'b1;
    logic [7:0] shift_in = '0;
    logic [7:0] last_rom = '0;
    logic [7:0] last_func = '0;
    int         bit_n = 0;
    int         read_n = 0;
    int         rom_cnt = 0;
    int         func_cnt = 0;
    int         read_cnt = 0;
    int         pulse_cnt = 0;
    int         low_ns = 0;
    time        t_fall;

    assign line = !(master_low || model_low); // Open drain with pull-up.

    initial proto_errors = 0;

    always begin
        @(posedge master_low);
        t_fall   = $time;
        send_bit = (mode == M_POLL) ? (read_n >= busy_polls) :
                   (read_n < 16) ? temp_word[read_n] : 1'b1;
        hold      = (mode == M_POLL || mode == M_SCRATCH) && !send_bit;
        model_low = hold; // A 0 holds the line past the master's sample point.
        @(negedge master_low);
        low_ns = int'($time - t_fall);
        if (hold && low_ns < 30 * TICK_NS) begin
            #(30 * TICK_NS - low_ns);
        end
        model_low = 1'b0;
        pulse_cnt++;
        if (low_ns >= RESET_MIN) begin
            if (mode == M_SCRATCH) begin
                conv_done = 1'b0; // The finished read uses up the conversion.
            end
            mode  = M_ROM;
            bit_n = 0;
            if (present) begin
                #(20 * TICK_NS);
                model_low = 1'b1;
                #(120 * TICK_NS);
                model_low = 1'b0;
            end
        end else if (mode == M_POLL || mode == M_SCRATCH) begin
            read_ok = (mode == M_POLL) ? !conv_done : (read_n < 16);
            if (mode == M_POLL && send_bit) begin
                conv_done = 1'b1;
            end
            read_n++;
            read_cnt++;
        end else begin
            shift_in = {low_ns <= SHORT_MAX, shift_in[7:1]};  // LSB first.
            bit_n++;
            if (bit_n == 8 && mode == M_ROM) begin
                bit_n    = 0;
                last_rom = shift_in;
                rom_cnt++;
                mode     = M_FUNC;
            end else if (bit_n == 8) begin
                bit_n     = 0;
                last_func = shift_in;
                func_cnt++;
                read_n    = 0;
                if (shift_in == `OW_CMD_CONVERT) begin
                    conv_done = 1'b0;
                    mode      = M_POLL;
                end else begin
                    mode = (shift_in == `OW_CMD_READ_SCRATCH) ? M_SCRATCH : M_ROM;
                end
            end
        end
    end

    a_rom_skip: assert property (
        @(posedge strobe) $changed(rom_cnt) |-> last_rom == `OW_CMD_SKIP_ROM
    ) else begin
        $display("ROM command other than Skip ROM received");
        proto_errors++;
    end

    a_func_known: assert property (
        @(posedge strobe) $changed(func_cnt) |->
            last_func inside {`OW_CMD_CONVERT, `OW_CMD_READ_SCRATCH}
    ) else begin
        $display("Unknown function command received");
        proto_errors++;
    end

    a_scratch_after_conv: assert property (
        @(posedge strobe) $changed(func_cnt) && last_func == `OW_CMD_READ_SCRATCH |-> conv_done
    ) else begin
        $display("Read Scratchpad issued before the conversion finished");
        proto_errors++;
    end

    a_read_legal: assert property (@(posedge strobe) $changed(read_cnt) |-> read_ok)
    else begin
        $display("Read slot after the conversion ended or past the temperature word");
        proto_errors++;
    end

    // Low time of every master pulse falls in one slot window.
    a_low_width: assert property (
        @(posedge strobe) $changed(pulse_cnt) |-> low_ns <= SHORT_MAX ||
            (low_ns >= W0_MIN && low_ns <= W0_MAX) || low_ns >= RESET_MIN
    ) else begin
        $display("Master low pulse of %0d ns fits no slot type", low_ns);
        proto_errors++;
    end

endmodule

`default_nettype wire

//--- tb_ow_temp_reader.sv
`timescale 1ns/1ps
`default_nettype none
`include "ow_defines.svh"

module tb_ow_temp_reader import ow_bus_pkg::*; ();

    localparam int PERIOD_NS = 10;
    localparam int LIMIT     = 200000; // Cycles allowed for one transaction.

    logic              strobe;
    logic              rst;
    logic              read_request;
    logic              line;
    logic              line_drive_low;
    logic              busy;
    logic              temp_valid;
    logic [15:0]       temp_raw;
    logic signed [7:0] temp_whole;
    logic [3:0]        temp_frac;
    logic              no_device;
    phase_t            phase;
    logic              present;
    logic [15:0]       sensor_word;
    int                busy_polls;
    int                proto_errors;
    int                errors = 0;
    int                tests = 0;
    int                bad_tests = 0;
    int                errs_before = 0;
    int                valid_seen = 0;
    int                nodev_seen = 0;
    logic              timed_out = 1'b0;

    ow_temp_reader i_dut (
        .strobe         (strobe),
        .rst            (rst),
        .read_request   (read_request),
        .line_in        (line),
        .line_drive_low (line_drive_low),
        .busy           (busy),
        .temp_valid     (temp_valid),
        .temp_raw       (temp_raw),
        .temp_whole     (temp_whole),
        .temp_frac      (temp_frac),
        .no_device      (no_device),
        .phase          (phase)
    );

    ds18b20_model #(.TICK_NS(PERIOD_NS * `OW_TICK_DIV)) i_model (
        .strobe       (strobe),
        .master_low   (line_drive_low),
        .present      (present),
        .temp_word    (sensor_word),
        .busy_polls   (busy_polls),
        .line         (line),
        .proto_errors (proto_errors)
    );

    initial begin
        strobe = 1'b0;
        forever #(PERIOD_NS / 2) strobe = ~strobe;
    end

    always @(negedge strobe) begin
        if (temp_valid) valid_seen++;
        if (no_device) nodev_seen++;
    end

    a_valid_single: assert property (
        @(posedge strobe) disable iff (rst) temp_valid |=> !temp_valid
    ) else begin
        $display("temp_valid was high for more than one cycle");
        errors++;
    end

    a_nodev_keeps: assert property (
        @(posedge strobe) disable iff (rst) no_device |-> $stable(temp_raw) && !busy
    ) else begin
        $display("no_device came with a changed result or with busy high");
        errors++;
    end

    a_busy_start: assert property (
        @(posedge strobe) disable iff (rst) $rose(busy) |-> $past(read_request) &&
            $past(phase) == PH_IDLE
    ) else begin
        $display("busy rose without an accepted request");
        errors++;
    end

    task automatic check_hex(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
        assert (got === exp) else begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout: %s", what);
        timed_out = 1'b1;
        errors++;
    endtask

    task automatic pulse_request();
        read_request = 1'b1;
        @(posedge strobe);
        #1 read_request = 1'b0;
    endtask

    task automatic wait_result();
        int start_v;
        int start_n;
        int cnt;
        start_v = valid_seen;
        start_n = nodev_seen;
        cnt     = 0;
        while (!timed_out && valid_seen == start_v && nodev_seen == start_n &&
               cnt < LIMIT) begin
            @(posedge strobe);
            cnt++;
        end
        if (cnt >= LIMIT) report_timeout("neither temp_valid nor no_device arrived");
        #1;
    endtask

    task automatic wait_busy();
        int cnt;
        cnt = 0;
        while (!timed_out && !busy && cnt < 20) begin
            @(posedge strobe);
            cnt++;
        end
        if (cnt >= 20) report_timeout("busy did not rise after a request");
        #1;
    endtask

    task automatic read_and_check(input logic [15:0] word, input int polls);
        int base_v;
        int base_n;
        sensor_word = word;
        busy_polls  = polls;
        present     = 1'b1;
        base_v      = valid_seen;
        base_n      = nodev_seen;
        pulse_request();
        wait_result();
        check_hex("temp_valid pulses", 16'(valid_seen - base_v), 16'd1);
        check_hex("no_device pulses", 16'(nodev_seen - base_n), 16'd0);
        check_hex("temp_raw", temp_raw, word);
        // Whole degrees round toward minus infinity.
        check_hex("temp_whole", {8'h00, temp_whole}, {8'h00, 8'($signed(word) >>> 4)});
        check_hex("temp_frac", {12'h000, temp_frac}, word & 16'h000F);
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors + proto_errors == errs_before) begin
            $display("Test %0d %s: ok", tests, name);
        end else begin
            bad_tests++;
            $display("Test %0d %s: errors", tests, name);
        end
        errs_before = errors + proto_errors;
    endtask

    initial begin
        logic [15:0] saved_raw;
        int          base_v;
        int          base_n;
        int          rom0;
        int          func0;
        void'($urandom(61));
        rst          = 1'b1;
        read_request = 1'b0;
        present      = 1'b1;
        sensor_word  = '0;
        busy_polls   = 0;
        repeat (8) @(posedge strobe);
        #1 rst = 1'b0;
        @(posedge strobe);
        #1;
        check_hex("line_drive_low", {15'h0, line_drive_low}, 16'h0);
        check_hex("busy", {15'h0, busy}, 16'h0);
        check_hex("temp_valid", {15'h0, temp_valid}, 16'h0);
        check_hex("no_device", {15'h0, no_device}, 16'h0);
        check_hex("phase", 16'(phase), 16'(PH_IDLE));
        end_test("reset state");

        read_and_check(16'($urandom_range(1, 2000)), int'($urandom_range(1, 10)));
        end_test("positive temperature");

        rom0  = i_model.rom_cnt;
        func0 = i_model.func_cnt;
        read_and_check(16'h0191, 3);
        check_hex("rom commands", 16'(i_model.rom_cnt - rom0), 16'd2);
        check_hex("function commands", 16'(i_model.func_cnt - func0), 16'd2);
        end_test("command sequence");

        read_and_check(16'(-int'($urandom_range(1, 880))), int'($urandom_range(1, 10)));
        read_and_check(16'($urandom), int'($urandom_range(1, 10)));
        end_test("negative and random words");

        present   = 1'b0;
        saved_raw = temp_raw;
        base_v    = valid_seen;
        base_n    = nodev_seen;
        pulse_request();
        wait_result();
        check_hex("no_device pulses", 16'(nodev_seen - base_n), 16'd1);
        check_hex("temp_valid pulses", 16'(valid_seen - base_v), 16'd0);
        check_hex("temp_raw", temp_raw, saved_raw);
        present = 1'b1;
        end_test("absent device");

        base_v = valid_seen;
        pulse_request();
        wait_busy();
        repeat (50) @(posedge strobe);
        #1;
        pulse_request(); // Lands in the middle of the transaction.
        wait_result();
        repeat (2000) @(posedge strobe);
        #1;
        check_hex("temp_valid pulses", 16'(valid_seen - base_v), 16'd1);
        check_hex("busy", {15'h0, busy}, 16'h0);
        end_test("request while busy");

        $display("%0d tests, %0d with errors, %0d check errors", tests, bad_tests,
                 errors + proto_errors);
        if (errors + proto_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+.
ow_bus_pkg.sv
temp_pkg.sv
ow_line_input.sv
ow_slot_engine.sv
ow_sequencer.sv
ow_temp_reader.sv
ds18b20_model.sv
tb_ow_temp_reader.sv
